//--- axi_read_node.f
hdl/axi_node_pkg.sv
hdl/xbar_link_if.sv
hdl/chan_slice.sv
hdl/rr_arbiter.sv
hdl/initiator_port.sv
hdl/target_port.sv
hdl/axi_read_node.sv
test/tb_clock.sv
test/axi_read_node_tb.sv

//--- Makefile
TOP ?= axi_read_node_tb
FLIST ?= axi_read_node.f
BUILD ?= obj_dir
LOG ?= sim.log
VFLAGS ?= -j 0

SRCS := $(wildcard hdl/*.sv test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(FLIST) $(SRCS)
	verilator --binary --assert --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD) $(VFLAGS)

run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "test passed" $(LOG) && ! grep -q "test failed" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

//--- test/axi_read_node_tb.sv
`timescale 1ns/1ps

module axi_read_node_tb;

	localparam int CLK_NS = 40;
	localparam int N_TESTS = 6;

	logic clk;
	logic rst_i;
	logic [2:0] s_arvalid_i;
	logic [2:0] s_arready_o;
	logic [11:0] s_arid_i;
	logic [95:0] s_araddr_i;
	logic [2:0] s_rvalid_o;
	logic [2:0] s_rready_i = '1;
	logic [11:0] s_rid_o;
	logic [95:0] s_rdata_o;
	logic [5:0] s_rresp_o;
	logic [1:0] m_arvalid_o;
	logic [1:0] m_arready_i = '1;
	logic [11:0] m_arid_o;
	logic [63:0] m_araddr_o;
	logic [1:0] m_rvalid_i = '0;
	logic [1:0] m_rready_o;
	logic [11:0] m_rid_i = '0;
	logic [63:0] m_rdata_i = '0;
	logic [3:0] m_rresp_i = '0;
	logic [127:0] cfg_start_addr_i;
	logic [127:0] cfg_end_addr_i;
	logic [3:0] cfg_valid_rule_i;
	logic [5:0] cfg_connectivity_map_i;

	int seed = 9;
	logic [31:0] rnd_w [axi_node_pkg::N_INIT];
	logic bp_on;
	logic fair_on;
	string cur_test;
	int errors = 0;
	int err_base;
	int n_run = 0;
	int n_failed = 0;

	// scoreboard with one read in flight per initiator
	logic [2:0] pend;
	logic [3:0] pend_id [axi_node_pkg::N_INIT];
	logic [31:0] pend_addr [axi_node_pkg::N_INIT];
	int issued;
	int answered;
	int wins [axi_node_pkg::N_INIT][axi_node_pkg::N_INIT];

	// target model state
	logic [1:0] tgt_acc;
	logic [1:0] tgt_fire;
	axi_node_pkg::rout_t tgt_beat [axi_node_pkg::N_TARG];
	axi_node_pkg::rout_t tq [axi_node_pkg::N_TARG][$];

	tb_clock #(.PERIOD_NS(CLK_NS)) u_clk (.clk_o(clk));

	axi_read_node uut (.*);

	// address map as configured below
	function automatic int decode_target(int i, logic [31:0] addr);
		if (addr <= 32'h0000_FFFF || (addr >= 32'h0002_0000 && addr <= 32'h0002_FFFF))
			return 0;
		if (addr >= 32'h0001_0000 && addr <= 32'h0001_FFFF && i != 2)
			return 1;
		return -1;
	endfunction

	task automatic compare_value(string what, logic [31:0] exp_v, logic [31:0] act_v);
		assert (act_v === exp_v) else begin
			$display("** Error %s %s: expected %h, actual %h", cur_test, what, exp_v, act_v);
			errors++;
		end
	endtask

	// stalled responses must hold
	for (genvar i = 0; i < axi_node_pkg::N_INIT; i++) begin : g_hold
		int fails = 0;
		a_r_hold: assert property (@(posedge clk) disable iff (rst_i)
			s_rvalid_o[i] && !s_rready_i[i] |=> s_rvalid_o[i] &&
			$stable(s_rid_o[i*4 +: 4]) && $stable(s_rdata_o[i*32 +: 32]) &&
			$stable(s_rresp_o[i*2 +: 2]))
			else begin
				$display("initiator %0d response changed while stalled", i);
				fails++;
			end
	end

	function automatic int stall_fail_count();
		return g_hold[0].fails + g_hold[1].fails + g_hold[2].fails;
	endfunction

	// monitor samples mid cycle
	always @(negedge clk) begin
		logic [1:0] idx;
		logic [31:0] addr;
		int t;
		logic waiting;
		if (rst_i) begin
			pend = '0;
			issued = 0;
			answered = 0;
			tgt_acc = '0;
			tgt_fire = '0;
		end else begin
			for (int j = 0; j < axi_node_pkg::N_TARG; j++) begin
				tgt_fire[j] = m_rvalid_i[j] && m_rready_o[j];
				tgt_acc[j] = m_arvalid_o[j] && m_arready_i[j];
				addr = m_araddr_o[j*32 +: 32];
				idx = m_arid_o[j*6 + 4 +: 2];
				tgt_beat[j] = '{id: m_arid_o[j*6 +: 6], data: addr ^ 32'(j),
					resp: axi_node_pkg::RESP_OKAY};
				if (tgt_acc[j]) begin
					assert (int'(idx) < axi_node_pkg::N_INIT && pend[idx]) else begin
						$display("target %0d got a read from initiator %0d with none outstanding",
							j, idx);
						errors++;
					end
					if (int'(idx) < axi_node_pkg::N_INIT) begin
						compare_value("arid", 32'(pend_id[idx]), 32'(m_arid_o[j*6 +: 4]));
						compare_value("araddr", pend_addr[idx], addr);
						compare_value("target", 32'(decode_target(int'(idx), addr)), 32'(j));
					end
				end
			end
			// nobody waits while another initiator wins twice
			if (fair_on) begin
				for (int i = 0; i < axi_node_pkg::N_INIT; i++) begin
					waiting = s_arvalid_i[i] && !s_arready_o[i];
					for (int k = 0; k < axi_node_pkg::N_INIT; k++) begin
						if (!waiting) begin
							wins[i][k] = 0;
						end else if (k != i && s_arvalid_i[k] && s_arready_o[k]) begin
							wins[i][k]++;
							assert (wins[i][k] < 2) else begin
								$display("initiator %0d waited while initiator %0d won twice", i, k);
								errors++;
							end
						end
					end
				end
			end
			for (int i = 0; i < axi_node_pkg::N_INIT; i++) begin
				if (s_rvalid_o[i] && s_rready_i[i]) begin
					assert (pend[i]) else begin
						$display("initiator %0d got a response with no read outstanding", i);
						errors++;
					end
					t = decode_target(i, pend_addr[i]);
					compare_value("rid", 32'(pend_id[i]), 32'(s_rid_o[i*4 +: 4]));
					compare_value("rresp", (t < 0) ? 32'(axi_node_pkg::RESP_DECERR) :
						32'(axi_node_pkg::RESP_OKAY), 32'(s_rresp_o[i*2 +: 2]));
					compare_value("rdata", (t < 0) ? 32'h0 : pend_addr[i] ^ 32'(t),
						s_rdata_o[i*32 +: 32]);
					pend[i] = 1'b0;
					answered++;
				end
				if (s_arvalid_i[i] && s_arready_o[i]) begin
					pend[i] = 1'b1;
					pend_id[i] = s_arid_i[i*4 +: 4];
					pend_addr[i] = s_araddr_i[i*32 +: 32];
					issued++;
				end
			end
		end
	end

	// target model and ready stalls drawing from seed
	always begin
		logic [31:0] rnd;
		axi_node_pkg::rout_t beat;
		@(negedge clk);
		for (int i = 0; i < axi_node_pkg::N_INIT; i++) begin
			rnd_w[i] = $random(seed);
		end
		rnd = $random(seed);
		@(posedge clk);
		#1;
		s_rready_i = bp_on ? rnd[4:2] : '1;
		for (int j = 0; j < axi_node_pkg::N_TARG; j++) begin
			if (tgt_acc[j]) begin
				tq[j].push_back(tgt_beat[j]);
			end
			if (tgt_fire[j]) begin
				void'(tq[j].pop_front());
				m_rvalid_i[j] = 1'b0;
			end
			if (!m_rvalid_i[j] && tq[j].size() > 0 && (!bp_on || rnd[j])) begin
				beat = tq[j][0];
				m_rvalid_i[j] = 1'b1;
				m_rid_i[j*6 +: 6] = beat.id;
				m_rdata_i[j*32 +: 32] = beat.data;
				m_rresp_i[j*2 +: 2] = beat.resp;
			end
			// request stalls let waiting initiators pile up under contention
			m_arready_i[j] = !(bp_on || fair_on) || rnd[j + 2];
		end
	end

	// one read that returns once its response is back
	task automatic issue_read(int i, logic [3:0] id, logic [31:0] addr);
		s_arid_i[i*4 +: 4] = id;
		s_araddr_i[i*32 +: 32] = addr;
		s_arvalid_i[i] = 1'b1;
		do @(negedge clk); while (!s_arready_o[i]);
		@(posedge clk);
		#1;
		s_arvalid_i[i] = 1'b0;
		while (pend[i]) @(posedge clk);
		#1;
	endtask

	task automatic read_burst(int i, int n, logic [31:0] mask);
		repeat (n) begin
			issue_read(i, rnd_w[i][3:0], rnd_w[i] & mask);
		end
	endtask

	task automatic start_test(string name);
		cur_test = name;
		err_base = errors + stall_fail_count();
	endtask

	task automatic end_test();
		int errs;
		errs = errors + stall_fail_count() - err_base;
		assert (issued == answered) else begin
			$display("%s: %0d reads issued but %0d answered", cur_test, issued, answered);
			errs++;
		end
		n_run++;
		if (errs == 0) begin
			$display("%s: ok", cur_test);
		end else begin
			$display("%s: %0d errors", cur_test, errs);
			n_failed++;
		end
	endtask

	initial begin
		#(N_TESTS * 200 * CLK_NS);
		$display("watchdog: run did not finish within %0d cycles", N_TESTS * 200);
		$display("test failed");
		$finish;
	end

	initial begin
		rst_i = 1'b1;
		s_arvalid_i = '0;
		s_arid_i = '0;
		s_araddr_i = '0;
		bp_on = 1'b0;
		fair_on = 1'b0;
		// region k = r * 2 + j with target 1 second region disabled
		cfg_start_addr_i = {32'h0004_0000, 32'h0002_0000, 32'h0001_0000, 32'h0000_0000};
		cfg_end_addr_i = {32'h0004_FFFF, 32'h0002_FFFF, 32'h0001_FFFF, 32'h0000_FFFF};
		cfg_valid_rule_i = 4'b0111;
		// initiator 2 cannot reach target 1
		cfg_connectivity_map_i = 6'b011111;
		repeat (4) @(posedge clk);
		#1;
		rst_i = 1'b0;

		start_test("routing");
		for (int i = 0; i < axi_node_pkg::N_INIT; i++) begin
			issue_read(i, rnd_w[i][3:0], 32'h0000_1230);
			issue_read(i, rnd_w[i][3:0], 32'h0002_8004);
			if (i != 2) begin
				issue_read(i, rnd_w[i][3:0], 32'h0001_4000);
			end
		end
		end_test();

		start_test("decode_error");
		for (int i = 0; i < axi_node_pkg::N_INIT; i++) begin
			issue_read(i, rnd_w[i][3:0], 32'h0003_0000);
			issue_read(i, rnd_w[i][3:0], 32'hFFFF_FFF0);
			issue_read(i, rnd_w[i][3:0], 32'h0004_1000);
		end
		end_test();

		start_test("connectivity");
		for (int i = 0; i < axi_node_pkg::N_INIT; i++) begin
			issue_read(i, rnd_w[i][3:0], 32'h0001_8000);
		end
		end_test();

		start_test("id_extension");
		for (int i = 0; i < axi_node_pkg::N_INIT; i++) begin
			read_burst(i, 4, 32'h0003_FFFC);
		end
		end_test();

		start_test("contention");
		fair_on = 1'b1;
		fork
			read_burst(0, 12, 32'h0000_FFFC);
			read_burst(1, 12, 32'h0000_FFFC);
			read_burst(2, 12, 32'h0000_FFFC);
		join
		fair_on = 1'b0;
		end_test();

		start_test("backpressure");
		bp_on = 1'b1;
		fork
			read_burst(0, 8, 32'h0007_FFFC);
			read_burst(1, 8, 32'h0007_FFFC);
			read_burst(2, 8, 32'h0007_FFFC);
		join
		bp_on = 1'b0;
		end_test();

		$display("%0d tests run, %0d failed", n_run, n_failed);
		if (n_failed == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

//--- test/tb_clock.sv
`timescale 1ns/1ps

// free running clock for the testbench
module tb_clock #(
	parameter int PERIOD_NS = 40
) (
	output logic clk_o
);

	initial begin
		clk_o = 1'b0;
		forever begin
			#(PERIOD_NS / 2);
			clk_o = ~clk_o;
		end
	end

endmodule

//--- hdl/axi_read_node.sv
`timescale 1ns/1ps

module axi_read_node (
	input  logic clk,
	input  logic rst_i,

	// initiator side
	input  logic [axi_node_pkg::N_INIT-1:0] s_arvalid_i,
	output logic [axi_node_pkg::N_INIT-1:0] s_arready_o,
	input  logic [axi_node_pkg::N_INIT*axi_node_pkg::ID_IN_W-1:0] s_arid_i,
	input  logic [axi_node_pkg::N_INIT*axi_node_pkg::ADDR_W-1:0] s_araddr_i,
	output logic [axi_node_pkg::N_INIT-1:0] s_rvalid_o,
	input  logic [axi_node_pkg::N_INIT-1:0] s_rready_i,
	output logic [axi_node_pkg::N_INIT*axi_node_pkg::ID_IN_W-1:0] s_rid_o,
	output logic [axi_node_pkg::N_INIT*axi_node_pkg::DATA_W-1:0] s_rdata_o,
	output logic [axi_node_pkg::N_INIT*2-1:0] s_rresp_o,

	// target side
	output logic [axi_node_pkg::N_TARG-1:0] m_arvalid_o,
	input  logic [axi_node_pkg::N_TARG-1:0] m_arready_i,
	output logic [axi_node_pkg::N_TARG*axi_node_pkg::ID_OUT_W-1:0] m_arid_o,
	output logic [axi_node_pkg::N_TARG*axi_node_pkg::ADDR_W-1:0] m_araddr_o,
	input  logic [axi_node_pkg::N_TARG-1:0] m_rvalid_i,
	output logic [axi_node_pkg::N_TARG-1:0] m_rready_o,
	input  logic [axi_node_pkg::N_TARG*axi_node_pkg::ID_OUT_W-1:0] m_rid_i,
	input  logic [axi_node_pkg::N_TARG*axi_node_pkg::DATA_W-1:0] m_rdata_i,
	input  logic [axi_node_pkg::N_TARG*2-1:0] m_rresp_i,

	// region k = r * N_TARG + j, connectivity bit i * N_TARG + j
	input  logic [axi_node_pkg::N_REGION*axi_node_pkg::N_TARG*axi_node_pkg::ADDR_W-1:0]
		cfg_start_addr_i,
	input  logic [axi_node_pkg::N_REGION*axi_node_pkg::N_TARG*axi_node_pkg::ADDR_W-1:0]
		cfg_end_addr_i,
	input  logic [axi_node_pkg::N_REGION*axi_node_pkg::N_TARG-1:0] cfg_valid_rule_i,
	input  logic [axi_node_pkg::N_INIT*axi_node_pkg::N_TARG-1:0] cfg_connectivity_map_i
);

	// row i of the link matrix
	for (genvar i = 0; i < axi_node_pkg::N_INIT; i++) begin : g_init
		xbar_link_if link [axi_node_pkg::N_TARG] ();
		axi_node_pkg::ar_req_t ar_req;
		axi_node_pkg::r_beat_t r_beat;

		assign ar_req.id = s_arid_i[i*axi_node_pkg::ID_IN_W +: axi_node_pkg::ID_IN_W];
		assign ar_req.addr = s_araddr_i[i*axi_node_pkg::ADDR_W +: axi_node_pkg::ADDR_W];
		assign s_rid_o[i*axi_node_pkg::ID_IN_W +: axi_node_pkg::ID_IN_W] = r_beat.id;
		assign s_rdata_o[i*axi_node_pkg::DATA_W +: axi_node_pkg::DATA_W] = r_beat.data;
		assign s_rresp_o[i*2 +: 2] = r_beat.resp;

		initiator_port u_init (
			.clk(clk),
			.rst_i(rst_i),
			.arvalid_i(s_arvalid_i[i]),
			.arready_o(s_arready_o[i]),
			.ar_req_i(ar_req),
			.rvalid_o(s_rvalid_o[i]),
			.rready_i(s_rready_i[i]),
			.r_beat_o(r_beat),
			.cfg_start_addr_i(cfg_start_addr_i),
			.cfg_end_addr_i(cfg_end_addr_i),
			.cfg_valid_rule_i(cfg_valid_rule_i),
			.conn_row_i(cfg_connectivity_map_i[i*axi_node_pkg::N_TARG +: axi_node_pkg::N_TARG]),
			.links(link)
		);
	end

	// column j, seen from the target
	for (genvar j = 0; j < axi_node_pkg::N_TARG; j++) begin : g_targ
		xbar_link_if link [axi_node_pkg::N_INIT] ();
		axi_node_pkg::ar_out_t ar_out;
		axi_node_pkg::rout_t r_in;

		assign m_arid_o[j*axi_node_pkg::ID_OUT_W +: axi_node_pkg::ID_OUT_W] = ar_out.id;
		assign m_araddr_o[j*axi_node_pkg::ADDR_W +: axi_node_pkg::ADDR_W] = ar_out.addr;
		assign r_in.id = m_rid_i[j*axi_node_pkg::ID_OUT_W +: axi_node_pkg::ID_OUT_W];
		assign r_in.data = m_rdata_i[j*axi_node_pkg::DATA_W +: axi_node_pkg::DATA_W];
		assign r_in.resp = m_rresp_i[j*2 +: 2];

		// tie link (i, j) of the row view to the column view
		for (genvar i = 0; i < axi_node_pkg::N_INIT; i++) begin : g_bridge
			assign link[i].ar_valid = g_init[i].link[j].ar_valid;
			assign link[i].ar_req = g_init[i].link[j].ar_req;
			assign g_init[i].link[j].ar_ready = link[i].ar_ready;
			assign g_init[i].link[j].r_valid = link[i].r_valid;
			assign g_init[i].link[j].r_beat = link[i].r_beat;
			assign link[i].r_ready = g_init[i].link[j].r_ready;
		end

		target_port u_targ (
			.clk(clk),
			.rst_i(rst_i),
			.m_arvalid_o(m_arvalid_o[j]),
			.m_arready_i(m_arready_i[j]),
			.m_ar_o(ar_out),
			.m_rvalid_i(m_rvalid_i[j]),
			.m_rready_o(m_rready_o[j]),
			.m_r_i(r_in),
			.links(link)
		);
	end

endmodule

//--- hdl/target_port.sv
`timescale 1ns/1ps

module target_port (
	input  logic clk,
	input  logic rst_i,
	output logic m_arvalid_o,
	input  logic m_arready_i,
	output axi_node_pkg::ar_out_t m_ar_o,
	input  logic m_rvalid_i,
	output logic m_rready_o,
	input  axi_node_pkg::rout_t m_r_i,
	xbar_link_if.targ links [axi_node_pkg::N_INIT]
);

	logic [axi_node_pkg::N_INIT-1:0] req_vec;
	logic [axi_node_pkg::N_INIT-1:0] grant;
	axi_node_pkg::ar_req_t [axi_node_pkg::N_INIT-1:0] req_cand;
	axi_node_pkg::ar_req_t req_win;
	logic [axi_node_pkg::INIT_IDX_W-1:0] win_idx;
	axi_node_pkg::ar_out_t ar_in;
	logic slice_ready;

	logic [axi_node_pkg::INIT_IDX_W-1:0] r_idx;
	logic [axi_node_pkg::N_INIT-1:0] route_hit;
	logic [axi_node_pkg::N_INIT-1:0] link_r_ready;

	rr_arbiter #(
		.N_REQ(axi_node_pkg::N_INIT)
	) u_req_arb (
		.clk(clk),
		.rst_i(rst_i),
		.req_i(req_vec),
		.grant_o(grant),
		.accept_i((|grant) & slice_ready)
	);

	always_comb begin
		req_win = '0;
		win_idx = '0;
		for (int i = 0; i < axi_node_pkg::N_INIT; i++) begin
			if (grant[i]) begin
				req_win = req_cand[i];
				win_idx = i[axi_node_pkg::INIT_IDX_W-1:0];
			end
		end
	end

	// tag the request with the issuing initiator
	assign ar_in = '{
		id: {win_idx, req_win.id},
		addr: req_win.addr
	};

	chan_slice #(
		.payload_t(axi_node_pkg::ar_out_t)
	) u_ar_slice (
		.clk(clk),
		.rst_i(rst_i),
		.in_valid_i(|grant),
		.in_ready_o(slice_ready),
		.in_data_i(ar_in),
		.out_valid_o(m_arvalid_o),
		.out_ready_i(m_arready_i),
		.out_data_o(m_ar_o)
	);

	// responses go back by the upper id bits
	assign r_idx = m_r_i.id[axi_node_pkg::ID_OUT_W-1 -: axi_node_pkg::INIT_IDX_W];

	always_comb begin
		route_hit = '0;
		for (int i = 0; i < axi_node_pkg::N_INIT; i++) begin
			if (int'(r_idx) == i) begin
				route_hit[i] = 1'b1;
			end
		end
	end

	for (genvar i = 0; i < axi_node_pkg::N_INIT; i++) begin : g_link
		assign req_vec[i] = links[i].ar_valid;
		assign req_cand[i] = links[i].ar_req;
		assign links[i].ar_ready = grant[i] & slice_ready;
		assign links[i].r_valid = m_rvalid_i & route_hit[i];
		assign links[i].r_beat = '{
			id: m_r_i.id[axi_node_pkg::ID_IN_W-1:0],
			data: m_r_i.data,
			resp: m_r_i.resp
		};
		assign link_r_ready[i] = links[i].r_ready;
	end

	assign m_rready_o = |(route_hit & link_r_ready);

	// a response must name an initiator that exists
	a_route_known: assert property (@(posedge clk) disable iff (rst_i)
		m_rvalid_i |-> int'(r_idx) < axi_node_pkg::N_INIT);

endmodule

//--- hdl/initiator_port.sv
`timescale 1ns/1ps

module initiator_port (
	input  logic clk,
	input  logic rst_i,
	input  logic arvalid_i,
	output logic arready_o,
	input  axi_node_pkg::ar_req_t ar_req_i,
	output logic rvalid_o,
	input  logic rready_i,
	output axi_node_pkg::r_beat_t r_beat_o,
	input  logic [axi_node_pkg::N_REGION*axi_node_pkg::N_TARG-1:0][axi_node_pkg::ADDR_W-1:0]
		cfg_start_addr_i,
	input  logic [axi_node_pkg::N_REGION*axi_node_pkg::N_TARG-1:0][axi_node_pkg::ADDR_W-1:0]
		cfg_end_addr_i,
	input  logic [axi_node_pkg::N_REGION*axi_node_pkg::N_TARG-1:0] cfg_valid_rule_i,
	input  logic [axi_node_pkg::N_TARG-1:0] conn_row_i,
	xbar_link_if.init links [axi_node_pkg::N_TARG]
);

	logic [axi_node_pkg::N_TARG-1:0] hit;
	logic [axi_node_pkg::N_TARG-1:0] sel;
	logic dec_err;
	logic [axi_node_pkg::N_TARG-1:0] link_ar_ready;

	logic err_pend_q;
	logic [axi_node_pkg::ID_IN_W-1:0] err_id_q;

	logic [axi_node_pkg::N_TARG:0] rsp_req;
	logic [axi_node_pkg::N_TARG:0] rsp_grant;
	axi_node_pkg::r_beat_t [axi_node_pkg::N_TARG:0] rsp_cand;
	axi_node_pkg::r_beat_t rsp_win;
	logic slice_ready;

	// region k = r * N_TARG + j belongs to target j
	always_comb begin
		int k;
		k = 0;
		hit = '0;
		for (int j = 0; j < axi_node_pkg::N_TARG; j++) begin
			for (int r = 0; r < axi_node_pkg::N_REGION; r++) begin
				k = r * axi_node_pkg::N_TARG + j;
				if (cfg_valid_rule_i[k] && conn_row_i[j] &&
						ar_req_i.addr >= cfg_start_addr_i[k] &&
						ar_req_i.addr <= cfg_end_addr_i[k]) begin
					hit[j] = 1'b1;
				end
			end
		end
	end

	// lowest numbered target wins
	assign sel = hit & (~hit + 1'b1);
	assign dec_err = (hit == '0);

	assign arready_o = dec_err ? !err_pend_q : |(sel & link_ar_ready);

	for (genvar j = 0; j < axi_node_pkg::N_TARG; j++) begin : g_link
		assign links[j].ar_valid = arvalid_i & sel[j];
		assign links[j].ar_req = ar_req_i;
		assign link_ar_ready[j] = links[j].ar_ready;
		assign rsp_req[j] = links[j].r_valid;
		assign rsp_cand[j] = links[j].r_beat;
		assign links[j].r_ready = rsp_grant[j] & slice_ready;
	end

	// one local decode error response at a time
	always_ff @(posedge clk) begin
		if (rst_i) begin
			err_pend_q <= 1'b0;
		end else if (arvalid_i && dec_err && !err_pend_q) begin
			err_pend_q <= 1'b1;
		end else if (rsp_grant[axi_node_pkg::N_TARG] && slice_ready) begin
			err_pend_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (arvalid_i && dec_err && !err_pend_q) begin
			err_id_q <= ar_req_i.id;
		end
	end

	assign rsp_req[axi_node_pkg::N_TARG] = err_pend_q;
	assign rsp_cand[axi_node_pkg::N_TARG] = '{
		id: err_id_q,
		data: '0,
		resp: axi_node_pkg::RESP_DECERR
	};

	rr_arbiter #(
		.N_REQ(axi_node_pkg::N_TARG + 1)
	) u_rsp_arb (
		.clk(clk),
		.rst_i(rst_i),
		.req_i(rsp_req),
		.grant_o(rsp_grant),
		.accept_i((|rsp_grant) & slice_ready)
	);

	always_comb begin
		rsp_win = '0;
		for (int k = 0; k <= axi_node_pkg::N_TARG; k++) begin
			if (rsp_grant[k]) begin
				rsp_win = rsp_cand[k];
			end
		end
	end

	chan_slice #(
		.payload_t(axi_node_pkg::r_beat_t)
	) u_r_slice (
		.clk(clk),
		.rst_i(rst_i),
		.in_valid_i(|rsp_grant),
		.in_ready_o(slice_ready),
		.in_data_i(rsp_win),
		.out_valid_o(rvalid_o),
		.out_ready_i(rready_i),
		.out_data_o(r_beat_o)
	);

endmodule

//--- hdl/rr_arbiter.sv
`timescale 1ns/1ps

module rr_arbiter #(
	parameter int N_REQ = 2
) (
	input  logic clk,
	input  logic rst_i,
	input  logic [N_REQ-1:0] req_i,
	output logic [N_REQ-1:0] grant_o,
	input  logic accept_i
);

	logic [$clog2(N_REQ)-1:0] last_q;
	logic [$clog2(N_REQ)-1:0] win_idx;

	// search starts just past the last winner
	always_comb begin
		int idx;
		logic found;
		idx = 0;
		found = 1'b0;
		grant_o = '0;
		win_idx = last_q;
		for (int k = 1; k <= N_REQ; k++) begin
			idx = (int'(last_q) + k) % N_REQ;
			if (!found && req_i[idx]) begin
				found = 1'b1;
				grant_o[idx] = 1'b1;
				win_idx = idx[$clog2(N_REQ)-1:0];
			end
		end
	end

	// rotate only once the granted item has moved
	always_ff @(posedge clk) begin
		if (rst_i) begin
			last_q <= '0;
		end else if (accept_i && (grant_o != '0)) begin
			last_q <= win_idx;
		end
	end

	a_grant_onehot: assert property (@(posedge clk) disable iff (rst_i)
		$onehot0(grant_o));

	a_grant_in_req: assert property (@(posedge clk) disable iff (rst_i)
		(grant_o & ~req_i) == '0);

endmodule

//--- hdl/chan_slice.sv
`timescale 1ns/1ps

module chan_slice #(
	parameter type payload_t = logic [31:0]
) (
	input  logic clk,
	input  logic rst_i,
	input  logic in_valid_i,
	output logic in_ready_o,
	input  payload_t in_data_i,
	output logic out_valid_o,
	input  logic out_ready_i,
	output payload_t out_data_o
);

	logic full_q;
	payload_t data_q;

	// take a new item when empty or when the current one leaves this cycle
	assign in_ready_o = !full_q || out_ready_i;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			full_q <= 1'b0;
		end else if (in_ready_o) begin
			full_q <= in_valid_i;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid_i && in_ready_o) begin
			data_q <= in_data_i;
		end
	end

	assign out_valid_o = full_q;
	assign out_data_o = data_q;

	// stalled output holds
	a_hold_stable: assert property (@(posedge clk) disable iff (rst_i)
		out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o));

endmodule

//--- hdl/xbar_link_if.sv
`timescale 1ns/1ps

// one initiator to target connection, read channels only
interface xbar_link_if;

	logic ar_valid;
	axi_node_pkg::ar_req_t ar_req;
	logic ar_ready;

	logic r_valid;
	axi_node_pkg::r_beat_t r_beat;
	logic r_ready;

	modport init (
		output ar_valid,
		output ar_req,
		input  ar_ready,
		input  r_valid,
		input  r_beat,
		output r_ready
	);

	modport targ (
		input  ar_valid,
		input  ar_req,
		output ar_ready,
		output r_valid,
		output r_beat,
		input  r_ready
	);

endinterface

//--- hdl/axi_node_pkg.sv
package axi_node_pkg;

	// node geometry
	localparam int N_INIT = 3;
	localparam int N_TARG = 2;
	localparam int N_REGION = 2;

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int ID_IN_W = 4;
	localparam int INIT_IDX_W = 2;
	// initiator index sits above the original id
	localparam int ID_OUT_W = ID_IN_W + INIT_IDX_W;

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_DECERR = 2'b11;

	// initiator side
	typedef struct packed {
		logic [ID_IN_W-1:0] id;
		logic [ADDR_W-1:0] addr;
	} ar_req_t;

	typedef struct packed {
		logic [ID_IN_W-1:0] id;
		logic [DATA_W-1:0] data;
		logic [1:0] resp;
	} r_beat_t;

	// target side, extended id
	typedef struct packed {
		logic [ID_OUT_W-1:0] id;
		logic [ADDR_W-1:0] addr;
	} ar_out_t;

	typedef struct packed {
		logic [ID_OUT_W-1:0] id;
		logic [DATA_W-1:0] data;
		logic [1:0] resp;
	} rout_t;

endpackage
